// ==== src/dcache_pkg.sv ====
/*
  Geometry of the data cache and the address layout shared by the RTL
  and the testbench. The cache is 4-way set associative with 16 sets
  and 16-byte lines, so one 32-bit address splits into a 24-bit tag,
  a 4-bit set index, a 2-bit word select and a 2-bit byte select.
  Import with a wildcard in the module header.
*/
package dcache_pkg;

    localparam int ADDR_W     = 32;    // byte address
    localparam int WORD_W     = 32;    // processor data
    localparam int LINE_WORDS = 4;
    localparam int LINE_W     = LINE_WORDS * WORD_W;
    localparam int OFFSET_W   = 4;     // byte offset inside a line
    localparam int NUM_SETS   = 16;
    localparam int INDEX_W    = 4;
    localparam int TAG_W      = ADDR_W - INDEX_W - OFFSET_W;
    localparam int NUM_WAYS   = 4;     // plru tree is written for 4
    localparam int WAY_W      = 2;

    // one address word, seen either as it travels on the ports
    // or cut into the fields the lookup works on
    typedef union packed {
        logic [ADDR_W-1:0] word;
        struct packed {
            logic [TAG_W-1:0]      tag;
            logic [INDEX_W-1:0]    index;
            logic [OFFSET_W-3:0]   word_sel;   // word within the line
            logic [1:0]            byte_sel;
        } f;
    } cache_addr_u;

endpackage

// ==== src/plru_table.sv ====
/*
  Tree pseudo-LRU state for every set, three bits per set.
  Bit 0 picks the older half, bit 1 the older way of ways 0/1 and
  bit 2 the older way of ways 2/3. An access pulse points the bits
  away from the accessed way at the next edge; the victim is read
  combinationally from the set at index.
*/
`timescale 1ns/100ps

module plru_table
    import dcache_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic [INDEX_W-1:0] index,
    input  logic               access_valid,
    input  logic [WAY_W-1:0]   access_way,
    output logic [WAY_W-1:0]   victim_way
);

    logic [NUM_SETS-1:0][2:0] tree_q;
    logic [2:0]               cur_bits;

    assign cur_bits = tree_q[index];

    // follow the tree towards the older side
    assign victim_way = cur_bits[0] ? {1'b1, cur_bits[2]} : {1'b0, cur_bits[1]};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tree_q <= '0;
        end else if (access_valid) begin
            tree_q[index][0] <= ~access_way[1];          // other half is older
            if (access_way[1]) begin
                tree_q[index][2] <= ~access_way[0];
            end else begin
                tree_q[index][1] <= ~access_way[0];
            end
        end
    end

endmodule

// ==== src/dcache_arrays.sv ====
/*
  Tag, valid, dirty and line storage for the four ways of 16 sets.
  Reads are registered and return one cycle after rd_index.
  A write to a way, selected by its bit in we, stores tag, dirty flag
  and line at wr_index and marks the entry valid; other ways keep
  their contents.
*/
`timescale 1ns/100ps

module dcache_arrays
    import dcache_pkg::*;
(
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic [INDEX_W-1:0]                 rd_index,
    input  logic [INDEX_W-1:0]                 wr_index,
    input  logic [NUM_WAYS-1:0]                we,
    input  logic [TAG_W-1:0]                   wr_tag,
    input  logic                               wr_dirty,
    input  logic [LINE_W-1:0]                  wr_line,
    output logic [NUM_WAYS-1:0][TAG_W-1:0]     rd_tag,
    output logic [NUM_WAYS-1:0]                rd_valid,
    output logic [NUM_WAYS-1:0]                rd_dirty,
    output logic [NUM_WAYS-1:0][LINE_W-1:0]    rd_line
);

    logic [TAG_W-1:0]  tag_mem  [NUM_WAYS][NUM_SETS];
    logic [LINE_W-1:0] line_mem [NUM_WAYS][NUM_SETS];

    logic [NUM_WAYS-1:0][NUM_SETS-1:0] valid_q;
    logic [NUM_WAYS-1:0][NUM_SETS-1:0] dirty_q;

    // tag and data rams
    always_ff @(posedge clk) begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (we[w]) begin
                tag_mem[w][wr_index]  <= wr_tag;
                line_mem[w][wr_index] <= wr_line;
            end
            rd_tag[w]  <= tag_mem[w][rd_index];
            rd_line[w] <= line_mem[w][rd_index];
        end
    end

    // state bits, cleared on reset so every line starts invalid
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q  <= '0;
            dirty_q  <= '0;
            rd_valid <= '0;
            rd_dirty <= '0;
        end else begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                if (we[w]) begin
                    valid_q[w][wr_index] <= 1'b1;
                    dirty_q[w][wr_index] <= wr_dirty;
                end
                rd_valid[w] <= valid_q[w][rd_index];
                rd_dirty[w] <= dirty_q[w][rd_index];
            end
        end
    end

endmodule

// ==== src/dcache_ctrl.sv ====
/*
  Cache controller. Holds the one outstanding processor request,
  compares the tags of all ways, returns the hit word and merges
  store bytes into the hit line. Misses run through the write-back
  and refill sequence, after which the set is read again and the
  request finishes as a hit in LOOKUP.
*/
`timescale 1ns/100ps

module dcache_ctrl
    import dcache_pkg::*;
(
    input  logic                               clk,
    input  logic                               rst_n,
    // processor side
    input  logic                               cpu_req,
    input  logic                               cpu_we,
    input  logic [ADDR_W-1:0]                  cpu_addr,
    input  logic [3:0]                         cpu_wstrb,
    input  logic [WORD_W-1:0]                  cpu_wdata,
    output logic                               cpu_ack,
    output logic [WORD_W-1:0]                  cpu_rdata,
    // memory side
    output logic                               mem_rd_req,
    output logic [ADDR_W-1:0]                  mem_rd_addr,
    input  logic                               mem_rd_rdy,
    input  logic                               mem_ret_valid,
    input  logic [LINE_W-1:0]                  mem_ret_data,
    output logic                               mem_wr_req,
    output logic [ADDR_W-1:0]                  mem_wr_addr,
    output logic [LINE_W-1:0]                  mem_wr_data,
    input  logic                               mem_wr_rdy,
    input  logic                               mem_wr_done,
    // arrays
    input  logic [NUM_WAYS-1:0][TAG_W-1:0]     rd_tag,
    input  logic [NUM_WAYS-1:0]                rd_valid,
    input  logic [NUM_WAYS-1:0]                rd_dirty,
    input  logic [NUM_WAYS-1:0][LINE_W-1:0]    rd_line,
    output logic [INDEX_W-1:0]                 arr_rd_index,
    output logic [INDEX_W-1:0]                 arr_wr_index,
    output logic [NUM_WAYS-1:0]                arr_we,
    output logic [TAG_W-1:0]                   arr_wr_tag,
    output logic                               arr_wr_dirty,
    output logic [LINE_W-1:0]                  arr_wr_line,
    // replacement
    input  logic [WAY_W-1:0]                   victim_way,
    output logic [INDEX_W-1:0]                 plru_index,
    output logic                               access_valid,
    output logic [WAY_W-1:0]                   access_way
);

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        MISS_DIRTY,
        WRITEBACK,
        MISS_CLEAN,
        REFILL,
        REFILL_DONE
    } state_e;

    state_e state_q;
    state_e state_d;

    cache_addr_u       in_addr;
    cache_addr_u       req_addr_q;
    logic              req_we_q;
    logic [3:0]        req_wstrb_q;
    logic [WORD_W-1:0] req_wdata_q;
    logic [WAY_W-1:0]  victim_q;           // way being replaced

    logic [NUM_WAYS-1:0] hit_vec;
    logic                hit_any;
    logic [WAY_W-1:0]    hit_way;

    logic [LINE_WORDS-1:0][WORD_W-1:0] hit_words;
    logic [LINE_WORDS-1:0][WORD_W-1:0] merged_words;
    logic [WORD_W-1:0]                 old_word;

    cache_addr_u wb_addr;
    cache_addr_u rf_addr;

    assign in_addr.word = cpu_addr;

    // request register, loaded once per request in IDLE
    always_ff @(posedge clk) begin
        if (state_q == IDLE && cpu_req) begin
            req_addr_q  <= in_addr;
            req_we_q    <= cpu_we;
            req_wstrb_q <= cpu_wstrb;
            req_wdata_q <= cpu_wdata;
        end
        if (state_q == LOOKUP && !hit_any) begin
            victim_q <= victim_way;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // tag compare over all ways
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            hit_vec[w] = rd_valid[w] && (rd_tag[w] == req_addr_q.f.tag);
            if (hit_vec[w]) begin
                hit_way = WAY_W'(w);
            end
        end
    end

    assign hit_any   = |hit_vec;
    assign hit_words = rd_line[hit_way];
    assign old_word  = hit_words[req_addr_q.f.word_sel];
    assign cpu_rdata = old_word;

    // byte merge of the store data into the hit line
    always_comb begin
        merged_words = hit_words;
        for (int b = 0; b < 4; b++) begin
            if (req_wstrb_q[b]) begin
                merged_words[req_addr_q.f.word_sel][b*8 +: 8] = req_wdata_q[b*8 +: 8];
            end
        end
    end

    // line aligned addresses for write-back and refill
    always_comb begin
        wb_addr            = req_addr_q;
        wb_addr.f.tag      = rd_tag[victim_q];
        wb_addr.f.word_sel = '0;
        wb_addr.f.byte_sel = '0;
        rf_addr            = req_addr_q;
        rf_addr.f.word_sel = '0;
        rf_addr.f.byte_sel = '0;
    end

    assign mem_wr_addr = wb_addr.word;
    assign mem_wr_data = rd_line[victim_q];   // set stays read during the miss
    assign mem_rd_addr = rf_addr.word;

    assign arr_rd_index = (state_q == IDLE) ? in_addr.f.index : req_addr_q.f.index;
    assign arr_wr_index = req_addr_q.f.index;
    assign arr_wr_tag   = req_addr_q.f.tag;
    assign plru_index   = req_addr_q.f.index;
    assign access_way   = hit_way;

    always_comb begin
        state_d      = state_q;
        cpu_ack      = 1'b0;
        mem_rd_req   = 1'b0;
        mem_wr_req   = 1'b0;
        arr_we       = '0;
        arr_wr_dirty = 1'b0;
        arr_wr_line  = merged_words;
        access_valid = 1'b0;
        case (state_q)
            IDLE: begin
                if (cpu_req) begin
                    state_d = LOOKUP;
                end
            end
            LOOKUP: begin
                if (hit_any) begin
                    cpu_ack      = 1'b1;
                    access_valid = 1'b1;
                    if (req_we_q) begin
                        arr_we       = hit_vec;   // store hit marks the line dirty
                        arr_wr_dirty = 1'b1;
                    end
                    state_d = IDLE;
                end else if (rd_valid[victim_way] && rd_dirty[victim_way]) begin
                    state_d = MISS_DIRTY;
                end else begin
                    state_d = MISS_CLEAN;
                end
            end
            MISS_DIRTY: begin
                mem_wr_req = 1'b1;
                if (mem_wr_rdy) begin
                    state_d = WRITEBACK;
                end
            end
            WRITEBACK: begin
                if (mem_wr_done) begin
                    state_d = MISS_CLEAN;
                end
            end
            MISS_CLEAN: begin
                mem_rd_req = 1'b1;
                if (mem_rd_rdy) begin
                    state_d = REFILL;
                end
            end
            REFILL: begin
                if (mem_ret_valid) begin
                    arr_we[victim_q] = 1'b1;
                    arr_wr_line      = mem_ret_data;   // clean copy of memory
                    state_d          = REFILL_DONE;
                end
            end
            REFILL_DONE: state_d = LOOKUP;   // set read again here
            default:     state_d = IDLE;
        endcase
    end

endmodule

// ==== src/dcache_top.sv ====
/*
  Blocking write-back data cache, 4-way, 16 sets of 16-byte lines.
  The processor holds cpu_req until a one-cycle cpu_ack. Misses go
  out on a line-wide read channel and a line-wide write channel,
  each with a request held until its ready.
*/
`timescale 1ns/100ps

module dcache_top
    import dcache_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              cpu_req,
    input  logic              cpu_we,
    input  logic [ADDR_W-1:0] cpu_addr,
    input  logic [3:0]        cpu_wstrb,
    input  logic [WORD_W-1:0] cpu_wdata,
    output logic              cpu_ack,
    output logic [WORD_W-1:0] cpu_rdata,
    output logic              mem_rd_req,
    output logic [ADDR_W-1:0] mem_rd_addr,
    input  logic              mem_rd_rdy,
    input  logic              mem_ret_valid,
    input  logic [LINE_W-1:0] mem_ret_data,
    output logic              mem_wr_req,
    output logic [ADDR_W-1:0] mem_wr_addr,
    output logic [LINE_W-1:0] mem_wr_data,
    input  logic              mem_wr_rdy,
    input  logic              mem_wr_done
);

    logic [NUM_WAYS-1:0][TAG_W-1:0]  rd_tag;
    logic [NUM_WAYS-1:0]             rd_valid;
    logic [NUM_WAYS-1:0]             rd_dirty;
    logic [NUM_WAYS-1:0][LINE_W-1:0] rd_line;
    logic [INDEX_W-1:0]              arr_rd_index;
    logic [INDEX_W-1:0]              arr_wr_index;
    logic [NUM_WAYS-1:0]             arr_we;
    logic [TAG_W-1:0]                arr_wr_tag;
    logic                            arr_wr_dirty;
    logic [LINE_W-1:0]               arr_wr_line;
    logic [WAY_W-1:0]                victim_way;
    logic [INDEX_W-1:0]              plru_index;
    logic                            access_valid;
    logic [WAY_W-1:0]                access_way;

    dcache_ctrl u_ctrl (
        .clk, .rst_n,
        .cpu_req, .cpu_we, .cpu_addr, .cpu_wstrb, .cpu_wdata, .cpu_ack, .cpu_rdata,
        .mem_rd_req, .mem_rd_addr, .mem_rd_rdy, .mem_ret_valid, .mem_ret_data,
        .mem_wr_req, .mem_wr_addr, .mem_wr_data, .mem_wr_rdy, .mem_wr_done,
        .rd_tag, .rd_valid, .rd_dirty, .rd_line,
        .arr_rd_index, .arr_wr_index, .arr_we, .arr_wr_tag, .arr_wr_dirty, .arr_wr_line,
        .victim_way, .plru_index, .access_valid, .access_way
    );

    dcache_arrays u_arrays (
        .clk, .rst_n,
        .rd_index (arr_rd_index),
        .wr_index (arr_wr_index),
        .we       (arr_we),
        .wr_tag   (arr_wr_tag),
        .wr_dirty (arr_wr_dirty),
        .wr_line  (arr_wr_line),
        .rd_tag, .rd_valid, .rd_dirty, .rd_line
    );

    plru_table u_plru (
        .clk, .rst_n,
        .index (plru_index),
        .access_valid, .access_way, .victim_way
    );

endmodule

// ==== verif/dcache_properties.sv ====
/*
  Handshake assertions for the data cache, bound into dcache_top.
  Memory requests hold their address and data until accepted, the
  read and write channels never request together, and cpu_ack only
  answers a request that is still raised.
*/
`timescale 1ns/100ps

module dcache_properties
    import dcache_pkg::*;
(
    input logic              clk,
    input logic              rst_n,
    input logic              cpu_req,
    input logic              cpu_ack,
    input logic              mem_rd_req,
    input logic              mem_rd_rdy,
    input logic [ADDR_W-1:0] mem_rd_addr,
    input logic              mem_wr_req,
    input logic              mem_wr_rdy,
    input logic [ADDR_W-1:0] mem_wr_addr,
    input logic [LINE_W-1:0] mem_wr_data
);

    int fails = 0;   // failed assertions so far

    rd_req_held: assert property (@(posedge clk) disable iff (!rst_n)
        mem_rd_req && !mem_rd_rdy |=> mem_rd_req && $stable(mem_rd_addr))
        else begin
            $error("read request dropped or changed before mem_rd_rdy");
            fails++;
        end

    wr_req_held: assert property (@(posedge clk) disable iff (!rst_n)
        mem_wr_req && !mem_wr_rdy |=>
            mem_wr_req && $stable(mem_wr_addr) && $stable(mem_wr_data))
        else begin
            $error("write request dropped or changed before mem_wr_rdy");
            fails++;
        end

    one_channel: assert property (@(posedge clk) disable iff (!rst_n)
        !(mem_rd_req && mem_wr_req))
        else begin
            $error("read and write requests raised together");
            fails++;
        end

    ack_with_req: assert property (@(posedge clk) disable iff (!rst_n)
        cpu_ack |-> cpu_req)
        else begin
            $error("cpu_ack without a pending cpu_req");
            fails++;
        end

endmodule

bind dcache_top dcache_properties u_props (.*);

// ==== verif/tb_dcache.sv ====
/*
  Testbench for the blocking data cache. Issues one processor request
  at a time, models a line-wide memory with random accept and return
  delays, and checks every read and every write-back line against a
  shadow copy of memory. Compile with dcache_top.f, top is tb_dcache.
*/
`timescale 1ns/100ps

module tb_dcache
    import dcache_pkg::*;
();

    typedef enum {M_IDLE, M_RD_ACC, M_RD_RET, M_WR_ACC, M_WR_DONE} mem_state_e;

    logic              clk, rst_n, cpu_req, cpu_we, cpu_ack;
    logic [ADDR_W-1:0] cpu_addr, mem_rd_addr, mem_wr_addr;
    logic [3:0]        cpu_wstrb;
    logic [WORD_W-1:0] cpu_wdata, cpu_rdata, exp_rdata;
    logic              mem_rd_req, mem_rd_rdy, mem_ret_valid;
    logic              mem_wr_req, mem_wr_rdy, mem_wr_done;
    logic [LINE_W-1:0] mem_ret_data, mem_wr_data;

    logic [WORD_W-1:0] shadow_q [logic [ADDR_W-1:0]];   // processor view, by word address
    logic [WORD_W-1:0] mem_q    [logic [ADDR_W-1:0]];   // lines written back
    logic [31:0]       stim_rng, mem_rng;
    logic              timed_out;
    int                errors, checks, writebacks;

    dcache_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic logic [31:0] stim_rand();
        stim_rng = lcg_next(stim_rng);
        return stim_rng;   // callers take upper bits
    endfunction

    function automatic int mem_delay();
        mem_rng = lcg_next(mem_rng);
        return int'(mem_rng[30:28]);   // 0 to 7 cycles
    endfunction

    function automatic logic [ADDR_W-1:0] make_addr(input logic [TAG_W-1:0] tag,
                                                    input logic [INDEX_W-1:0] index,
                                                    input logic [1:0] word_sel);
        cache_addr_u a;
        a.f.tag      = tag;
        a.f.index    = index;
        a.f.word_sel = word_sel;
        a.f.byte_sel = 2'b00;
        return a.word;
    endfunction

    // initial memory content, a function of the whole word address
    function automatic logic [WORD_W-1:0] init_word(input logic [ADDR_W-1:0] a);
        return {a[15:0], a[31:16]} ^ 32'h3c5a_96e1;
    endfunction

    // expected value of one word as the processor should see it
    function automatic logic [WORD_W-1:0] ref_word(input logic [ADDR_W-1:0] addr);
        logic [ADDR_W-1:0] a;
        a = {addr[ADDR_W-1:2], 2'b00};
        return shadow_q.exists(a) ? shadow_q[a] : init_word(a);
    endfunction

    function automatic logic [WORD_W-1:0] merge_bytes(input logic [WORD_W-1:0] old_w,
                                                      input logic [WORD_W-1:0] new_w,
                                                      input logic [3:0] strb);
        logic [WORD_W-1:0] res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) res[b*8 +: 8] = new_w[b*8 +: 8];
        end
        return res;
    endfunction

    function automatic logic [LINE_W-1:0] read_line(input logic [ADDR_W-1:0] line_addr);
        logic [LINE_W-1:0] data;
        logic [ADDR_W-1:0] a;
        data = '0;
        for (int i = 0; i < LINE_WORDS; i++) begin
            a = line_addr + ADDR_W'(4 * i);
            data[i*WORD_W +: WORD_W] = mem_q.exists(a) ? mem_q[a] : init_word(a);
        end
        return data;
    endfunction

    // one request, held until cpu_ack; skipped once the cache has hung
    task automatic access(input logic we, input logic [ADDR_W-1:0] addr,
                          input logic [3:0] strb, input logic [WORD_W-1:0] wdata);
        int                cycles;
        logic [WORD_W-1:0] old_w;
        if (!timed_out) begin
            old_w     = ref_word(addr);
            exp_rdata = old_w;
            cpu_req   = 1'b1;
            cpu_we    = we;
            cpu_addr  = addr;
            cpu_wstrb = strb;
            cpu_wdata = wdata;
            cycles    = 0;
            @(negedge clk);
            while (!cpu_ack && cycles < 100) begin   // a dirty miss needs about 40
                @(negedge clk);
                cycles++;
            end
            if (!cpu_ack) begin
                errors++;
                timed_out = 1'b1;
                $display("no cpu_ack within 100 cycles for request to %h", addr);
            end else if (we) begin
                shadow_q[{addr[ADDR_W-1:2], 2'b00}] = merge_bytes(old_w, wdata, strb);
            end
            @(posedge clk);
            #1;
            cpu_req = 1'b0;
            cpu_we  = 1'b0;
        end
    endtask

    always @(negedge clk) begin : compare
        if (rst_n && cpu_req && cpu_ack && !cpu_we) begin
            checks++;
            if (cpu_rdata !== exp_rdata) begin
                errors++;
                $display("Error cpu_rdata at %h: got %h expected %h",
                         cpu_addr, cpu_rdata, exp_rdata);
            end
        end
    end

    initial begin : memory_model
        mem_state_e        st;
        int                cnt;
        logic [ADDR_W-1:0] line_addr, a;
        st = M_IDLE;
        cnt = 0;
        line_addr = '0;
        forever begin
            @(posedge clk);
            #1;
            {mem_rd_rdy, mem_ret_valid, mem_wr_rdy, mem_wr_done} = 4'b0000;
            if (st == M_IDLE && mem_rd_req) begin
                cnt = mem_delay();
                st  = M_RD_ACC;
            end else if (st == M_IDLE && mem_wr_req) begin
                cnt = mem_delay();
                st  = M_WR_ACC;
            end
            if (cnt > 0) begin
                cnt--;   // stall this cycle
            end else if (st == M_RD_ACC) begin
                mem_rd_rdy = 1'b1;
                line_addr  = mem_rd_addr;
                cnt        = mem_delay();
                st         = M_RD_RET;
            end else if (st == M_RD_RET) begin
                mem_ret_valid = 1'b1;
                mem_ret_data  = read_line(line_addr);
                st            = M_IDLE;
            end else if (st == M_WR_ACC) begin
                mem_wr_rdy = 1'b1;
                writebacks++;
                for (int i = 0; i < LINE_WORDS; i++) begin
                    a = mem_wr_addr + ADDR_W'(4 * i);
                    if (mem_wr_data[i*WORD_W +: WORD_W] !== ref_word(a)) begin
                        errors++;
                        $display("Error mem_wr_data at %h: got %h expected %h",
                                 a, mem_wr_data[i*WORD_W +: WORD_W], ref_word(a));
                    end
                    mem_q[a] = mem_wr_data[i*WORD_W +: WORD_W];
                end
                cnt = mem_delay();
                st  = M_WR_DONE;
            end else if (st == M_WR_DONE) begin
                mem_wr_done = 1'b1;
                st          = M_IDLE;
            end
        end
    end

    initial begin : stimulus
        logic [31:0]       r;
        logic [ADDR_W-1:0] addr;
        int                wb_start;
        {rst_n, cpu_req, cpu_we, cpu_wstrb, cpu_addr, cpu_wdata} = '0;
        {mem_rd_rdy, mem_ret_valid, mem_wr_rdy, mem_wr_done, mem_ret_data} = '0;
        {errors, checks, writebacks} = '0;
        timed_out = 1'b0;
        exp_rdata = '0;
        stim_rng  = 32'hea87;
        mem_rng   = lcg_next(32'hea87) ^ 32'h5a5a_0000;   // own stream for delays
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        repeat (4) begin   // quiet with no request
            @(negedge clk);
            if (cpu_ack || mem_rd_req || mem_wr_req) begin
                errors++;
                $display("cache outputs active with no request after reset");
            end
        end
        @(posedge clk);
        #1;
        for (int i = 0; i < 16; i++) begin   // cold misses, then hits in the same lines
            access(1'b0, make_addr(TAG_W'(24'h001000 + i % 8), INDEX_W'(i % 8), 2'(i)), 4'h0, '0);
        end
        addr = make_addr(24'h002000, 4'h3, 2'd1);
        access(1'b1, addr, 4'b0110, 32'hdead_beef);   // write-allocate
        for (int w = 0; w < LINE_WORDS; w++) begin
            access(1'b0, make_addr(24'h002000, 4'h3, 2'(w)), 4'h0, '0);
        end
        access(1'b1, addr, 4'b1001, 32'h1357_9bdf);   // store hit
        access(1'b0, addr, 4'h0, '0);
        wb_start = writebacks;
        for (int i = 0; i < 12; i++) begin   // six lines through one 4-way set
            access(i < 6, make_addr(TAG_W'(24'h003000 + i % 6), 4'hb, 2'd2), 4'hf,
                   32'ha500_0000 + i);
        end
        if (writebacks == wb_start) begin
            errors++;
            $display("no dirty write-back seen while filling one set");
        end
        for (int n = 0; n < 600; n++) begin
            r    = stim_rand();
            addr = make_addr(TAG_W'(24'h000040 + r[31:28] % 6), INDEX_W'(r[27:26]), r[25:24]);
            access(r[23], addr, r[22:19], stim_rand());
            if (r[18]) begin   // leave cpu_req low for a cycle
                @(posedge clk);
                #1;
            end
        end
        errors = errors + dut.u_props.fails;
        $display("reads checked %0d, write-backs %0d, assertion failures %0d, errors %0d",
                 checks, writebacks, dut.u_props.fails, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== dcache_top.f ====
src/dcache_pkg.sv
src/plru_table.sv
src/dcache_arrays.sv
src/dcache_ctrl.sv
src/dcache_top.sv
verif/dcache_properties.sv
verif/tb_dcache.sv
